// ==== all.f ====
+incdir+include
logic/fetch_pkg.sv
logic/fetch_ctrl_if.sv
logic/fetch_fsm.sv
logic/burst_tracker.sv
logic/line_writer.sv
logic/fetcher_top.sv
tb/tb_fetcher.sv

// ==== run.sh ====
#!/bin/sh
# Build tb_fetcher with Verilator, run it, and read the result from its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetcher -f all.f \
    && ./obj_dir/Vtb_fetcher | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tb/tb_fetcher.sv ====
/*
  Directed testbench for the burst fetcher. The AXI4 read memory model answers
  each accepted AR with 16 beats whose data follow from address and beat index.
  Inputs change on the falling edge, where the coming handshakes are also resolved.
*/
`timescale 1ns/100ps
`include "fetch_defines.svh"

module tb_fetcher;

    localparam int TIMEOUT = 20000;   // Cycles allowed per fetch

    logic                  i_clk = 1'b0;
    logic                  i_reset_n;
    logic                  i_fetch_en;
    fetch_pkg::cmd_addr_t  i_fetch_addr;
    fetch_pkg::target_e    i_fetch_target;
    logic                  o_fetch_done;
    logic                  i_arready = 1'b0;
    logic                  o_arvalid;
    fetch_pkg::axi_id_t    o_arid;
    fetch_pkg::axi_addr_t  o_araddr;
    logic [7:0]            o_arlen;
    logic [2:0]            o_arsize;
    logic [1:0]            o_arburst;
    logic                  i_rvalid = 1'b0;
    fetch_pkg::line_t      i_rdata = '0;
    logic                  i_rlast = 1'b0;
    logic                  o_rready;
    logic                  o_buf_wr_en;
    fetch_pkg::line_addr_t o_buf_wr_addr;
    fetch_pkg::line_t      o_buf_wr_data;
    fetch_pkg::target_e    o_buf_wr_target;

    // Memory model and scoreboard state
    fetch_pkg::axi_addr_t  ar_q[$];            // Accepted bursts, oldest first
    int                    beat_idx = 0;       // Next beat of ar_q[0]
    logic                  r_taken = 1'b0;
    logic                  ar_taken = 1'b0;
    logic                  done_prev = 1'b0;
    int                    ar_stall_pct = 0;
    int                    r_stall_pct = 0;
    logic [31:0]           rng_state = 32'hcd3efd35;
    fetch_pkg::cmd_addr_t  exp_base = '0;
    fetch_pkg::target_e    exp_target = fetch_pkg::TARGET_LEFT;
    int                    ar_cnt = 0;
    int                    wr_cnt = 0;
    int                    done_cnt = 0;
    int                    check_cnt = 0;
    int                    err_cnt = 0;
    int                    timeout_cnt = 0;

    always #10 i_clk = ~i_clk;   // 20 ns period

    fetcher_top DUT (.*);

    // ============================================================
    // Reference rules and helpers
    // ============================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic roll_stall(input int pct);
        rng_state = xorshift32(rng_state);
        return (rng_state % 100) < pct;
    endfunction

    // Page 2, two zero bits, line address, 32-byte beats
    function automatic fetch_pkg::axi_addr_t burst_addr(input fetch_pkg::cmd_addr_t base,
                                                       input int k);
        fetch_pkg::cmd_addr_t first_line;
        first_line = base + fetch_pkg::cmd_addr_t'(k * `FETCH_BEATS);
        return {9'd2, 2'b00, first_line, 5'b00000};
    endfunction

    function automatic fetch_pkg::line_t beat_pattern(input fetch_pkg::axi_addr_t addr,
                                                     input int beat);
        fetch_pkg::line_t p;
        int               w;
        for (w = 0; w < 8; w++) begin
            p[w*32 +: 32] = addr[41:10] ^ addr[31:0] ^ (32'(w) << 24) ^
                            (32'(beat) * 32'h01010101);
        end
        return p;
    endfunction

    function automatic fetch_pkg::line_t line_data(input int line);
        return beat_pattern(burst_addr(exp_base, line / `FETCH_BEATS), line % `FETCH_BEATS);
    endfunction

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("error at %0t: %s got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        check_cnt++;
        assert (cond === 1'b1) else begin
            err_cnt++;
            $display("error at %0t: %s", $time, what);
        end
    endtask

    // ============================================================
    // AXI4 read memory model
    // ============================================================
    always @(negedge i_clk) begin
        if (!(i_rvalid && !r_taken)) begin   // Unaccepted beat stays put
            if (ar_q.size() > 0 && !roll_stall(r_stall_pct)) begin
                i_rvalid = 1'b1;
                i_rdata  = beat_pattern(ar_q[0], beat_idx);
                i_rlast  = (beat_idx == `FETCH_BEATS - 1);
            end else begin
                i_rvalid = 1'b0;
                i_rlast  = 1'b0;
            end
        end
        i_arready = !roll_stall(ar_stall_pct);

        // Transfers of the coming rising edge
        r_taken  = i_rvalid && o_rready;
        ar_taken = o_arvalid && i_arready;
        if (r_taken) begin
            if (i_rlast) begin
                void'(ar_q.pop_front());
                beat_idx = 0;
            end else begin
                beat_idx++;
            end
        end
        if (ar_taken) begin
            check_value("o_araddr", o_araddr, burst_addr(exp_base, ar_cnt));
            check_value("o_arid", o_arid, 8'(32'hFE + ar_cnt));   // Wraps past FF
            check_value("o_arlen", o_arlen, 15);
            check_value("o_arsize", o_arsize, 5);
            check_value("o_arburst", o_arburst, 1);               // INCR
            ar_q.push_back(o_araddr);
            ar_cnt++;
        end
        expect_true(ar_q.size() <= `FETCH_MAX_OUT, "more than 6 bursts outstanding at once");
    end

    // Line-buffer writes and done pulse
    always @(negedge i_clk) begin
        if (i_reset_n) begin
            if (o_buf_wr_en) begin
                check_value("o_buf_wr_addr", o_buf_wr_addr, wr_cnt);
                check_value("o_buf_wr_data", o_buf_wr_data, line_data(wr_cnt));
                check_value("o_buf_wr_target", o_buf_wr_target, exp_target);
                wr_cnt++;
            end
            if (o_fetch_done) begin
                expect_true(!done_prev, "o_fetch_done stayed high longer than one cycle");
                if (!done_prev) begin
                    done_cnt++;
                end
            end
            done_prev = o_fetch_done;
        end
    end

    // ============================================================
    // Test steps
    // ============================================================
    task automatic run_fetch(input fetch_pkg::cmd_addr_t base, input fetch_pkg::target_e tgt,
                             input int ar_pct, input int r_pct);
        int cycles;
        @(negedge i_clk);
        exp_base       = base;
        exp_target     = tgt;
        ar_cnt         = 0;
        wr_cnt         = 0;
        done_cnt       = 0;
        ar_stall_pct   = ar_pct;
        r_stall_pct    = r_pct;
        i_fetch_en     = 1'b0;
        i_fetch_addr   = base;
        i_fetch_target = tgt;
        @(negedge i_clk);
        i_fetch_en = 1'b1;                      // Rising edge
        @(negedge i_clk);
        i_fetch_addr   = ~base;                 // Command already captured
        i_fetch_target = (tgt == fetch_pkg::TARGET_LEFT) ? fetch_pkg::TARGET_RIGHT
                                                         : fetch_pkg::TARGET_LEFT;
        cycles = 0;
        while (!o_fetch_done && cycles < TIMEOUT) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_fetch_done) begin
            timeout_cnt++;
            $display("timeout: o_fetch_done did not arrive within %0d cycles", TIMEOUT);
        end
        repeat (8) @(negedge i_clk);            // Catch a second done pulse
        check_value("write count", wr_cnt, `FETCH_LINES);
        check_value("AR transfer count", ar_cnt, `FETCH_BURSTS);
        check_value("done pulse count", done_cnt, 1);
        check_value("bursts left open", ar_q.size(), 0);
    endtask

    // i_fetch_en stays high from the last fetch
    task automatic check_no_restart(input int n);
        int i;
        int ar_before;
        ar_before = ar_cnt;
        for (i = 0; i < n; i++) begin
            @(negedge i_clk);
            expect_true(!o_arvalid, "o_arvalid rose while i_fetch_en was only held high");
        end
        check_value("AR transfers while held", ar_cnt - ar_before, 0);
    endtask

    task automatic test_reset();
        int i;
        i_reset_n = 1'b0;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_reset_n = 1'b1;
        for (i = 0; i < 12; i++) begin
            @(negedge i_clk);
            check_value("o_arvalid", o_arvalid, 0);
            check_value("o_rready", o_rready, 0);
            check_value("o_buf_wr_en", o_buf_wr_en, 0);
            check_value("o_fetch_done", o_fetch_done, 0);
        end
    endtask

    task automatic test_left_fetch();
        run_fetch(26'h0000100, fetch_pkg::TARGET_LEFT, 0, 0);   // Also checks AR fields
        check_no_restart(40);
    endtask

    task automatic test_back_pressure();
        run_fetch(26'h2a5c3f0, fetch_pkg::TARGET_RIGHT, 35, 45);
    endtask

    task automatic test_edge_start();
        check_no_restart(60);
        run_fetch(26'h3ffff80, fetch_pkg::TARGET_LEFT, 20, 10);  // Line address wraps
    endtask

    initial begin
        i_reset_n      = 1'b0;
        i_fetch_en     = 1'b0;
        i_fetch_addr   = '0;
        i_fetch_target = fetch_pkg::TARGET_LEFT;

        test_reset();
        test_left_fetch();
        test_back_pressure();
        test_edge_start();

        $display("summary: %0d checks, %0d errors, %0d timeouts",
                 check_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_fetcher

// ==== logic/fetcher_top.sv ====
/*
  Burst fetcher top: copies 528 lines from AXI4 memory into a line buffer.
  Only the AXI4 read channels are present. rready is high in ACTIVE and
  DRAIN only, and never drops inside a fetch.
*/
`timescale 1ns/100ps

module fetcher_top (
    input  logic                  i_clk,
    input  logic                  i_reset_n,

    // ============================================================
    // Command
    // ============================================================
    input  logic                  i_fetch_en,      // Rising edge starts
    input  fetch_pkg::cmd_addr_t  i_fetch_addr,    // Line address
    input  fetch_pkg::target_e    i_fetch_target,
    output logic                  o_fetch_done,

    // ============================================================
    // AXI4 read
    // ============================================================
    input  logic                  i_arready,
    output logic                  o_arvalid,
    output fetch_pkg::axi_id_t    o_arid,
    output fetch_pkg::axi_addr_t  o_araddr,
    output logic [7:0]            o_arlen,
    output logic [2:0]            o_arsize,
    output logic [1:0]            o_arburst,
    input  logic                  i_rvalid,
    input  fetch_pkg::line_t      i_rdata,
    input  logic                  i_rlast,
    output logic                  o_rready,

    // Line buffer write
    output logic                  o_buf_wr_en,
    output fetch_pkg::line_addr_t o_buf_wr_addr,
    output fetch_pkg::line_t      o_buf_wr_data,
    output fetch_pkg::target_e    o_buf_wr_target
);

    fetch_ctrl_if ctrl_if ();

    fetch_fsm u_fsm (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_fetch_en     (i_fetch_en),
        .i_fetch_addr   (i_fetch_addr),
        .i_fetch_target (i_fetch_target),
        .o_fetch_done   (o_fetch_done),
        .ctrl           (ctrl_if.fsm)
    );

    burst_tracker u_tracker (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_arready (i_arready),
        .i_rvalid  (i_rvalid),
        .i_rlast   (i_rlast),
        .o_arvalid (o_arvalid),
        .o_arid    (o_arid),
        .o_araddr  (o_araddr),
        .o_arlen   (o_arlen),
        .o_arsize  (o_arsize),
        .o_arburst (o_arburst),
        .ctrl      (ctrl_if.tracker)
    );

    line_writer u_writer (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_rvalid        (i_rvalid),
        .i_rdata         (i_rdata),
        .o_buf_wr_en     (o_buf_wr_en),
        .o_buf_wr_addr   (o_buf_wr_addr),
        .o_buf_wr_data   (o_buf_wr_data),
        .o_buf_wr_target (o_buf_wr_target),
        .ctrl            (ctrl_if.writer)
    );

    assign o_rready = ctrl_if.rd_en;   // Same gate the tracker and writer count with

endmodule : fetcher_top

// ==== logic/line_writer.sv ====
/*
  Line-buffer write path. One write per accepted read beat, one cycle later.
  Addresses run linearly from 0; the target is the command's, for all lines.
*/
`timescale 1ns/100ps
`include "fetch_defines.svh"

module line_writer (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_rvalid,
    input  fetch_pkg::line_t      i_rdata,
    output logic                  o_buf_wr_en,
    output fetch_pkg::line_addr_t o_buf_wr_addr,
    output fetch_pkg::line_t      o_buf_wr_data,
    output fetch_pkg::target_e    o_buf_wr_target,
    fetch_ctrl_if.writer          ctrl
);

    fetch_pkg::line_addr_t beat_cnt_q;   // Beats accepted this fetch
    logic                  beat_fire;

    assign beat_fire = i_rvalid && ctrl.rd_en;

    // ============================================================
    // Beat counter
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n || ctrl.start) begin
            beat_cnt_q <= '0;
        end else if (beat_fire) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
        end
    end

    assign ctrl.lines_done = (beat_cnt_q == `FETCH_LINES);

    // Registered write, enable only is reset
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            o_buf_wr_en <= 1'b0;
        end else begin
            o_buf_wr_en <= beat_fire;
        end
    end

    always_ff @(posedge i_clk) begin
        if (beat_fire) begin
            o_buf_wr_addr   <= beat_cnt_q;     // Linear line 0..527
            o_buf_wr_data   <= i_rdata;
            o_buf_wr_target <= ctrl.target;
        end
    end

    a_addr_range: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_buf_wr_en |-> o_buf_wr_addr < `FETCH_LINES);

    // Once every line is in, memory has nothing left to send
    a_no_extra: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        ctrl.lines_done && ctrl.rd_en |-> !i_rvalid);

endmodule : line_writer

// ==== logic/burst_tracker.sv ====
/*
  AXI4 read-address side. Raises the next AR a few beats before the current
  burst's rlast so bursts run back to back. At most FETCH_MAX_OUT bursts open.
  Fixed INCR bursts of 16 x 32 bytes; arid counts up from FETCH_ID_BASE.
*/
`timescale 1ns/100ps
`include "fetch_defines.svh"

module burst_tracker (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_arready,
    input  logic                 i_rvalid,
    input  logic                 i_rlast,
    output logic                 o_arvalid,
    output fetch_pkg::axi_id_t   o_arid,
    output fetch_pkg::axi_addr_t o_araddr,
    output logic [7:0]           o_arlen,
    output logic [2:0]           o_arsize,
    output logic [1:0]           o_arburst,
    fetch_ctrl_if.tracker        ctrl
);

    localparam int OUT_W   = $clog2(`FETCH_MAX_OUT + 1);
    localparam int ISSUE_W = $clog2(`FETCH_BURSTS + 1);
    localparam int CD_W    = $clog2(`FETCH_BEATS);

    logic                 ar_pending_q;    // Drives arvalid
    logic [ISSUE_W-1:0]   issued_q;        // ARs accepted this fetch
    logic [OUT_W-1:0]     out_cnt_q;       // Open bursts
    logic                 burst_active_q;  // Data of some burst still due
    logic [CD_W-1:0]      beats_left_q;    // Beats to rlast of current burst
    fetch_pkg::axi_id_t   id_q;
    fetch_pkg::cmd_addr_t burst_line;
    logic                 ar_fire, beat_fire, last_fire;
    logic                 window_open;

    assign ar_fire   = ar_pending_q && i_arready;
    assign beat_fire = i_rvalid && ctrl.rd_en;
    assign last_fire = beat_fire && i_rlast;

    // Idle, or close to the end of the current burst
    assign window_open = !burst_active_q ||
                         (beats_left_q >= 1 && beats_left_q <= `FETCH_PREDICT);

    // ============================================================
    // Request and counters
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n || ctrl.start) begin
            ar_pending_q <= 1'b0;
            issued_q     <= '0;
            out_cnt_q    <= '0;
            id_q         <= `FETCH_ID_BASE;
        end else begin
            if (ar_fire) begin
                ar_pending_q <= 1'b0;
                issued_q     <= issued_q + 1'b1;
                id_q         <= id_q + 1'b1;          // Wraps at 8 bits
            end else if (ctrl.issue_en && !ar_pending_q && issued_q < `FETCH_BURSTS &&
                         out_cnt_q < `FETCH_MAX_OUT && window_open) begin
                ar_pending_q <= 1'b1;
            end
            case ({ar_fire, last_fire})
                2'b10:   out_cnt_q <= out_cnt_q + 1'b1;
                2'b01:   out_cnt_q <= out_cnt_q - 1'b1;
                default: out_cnt_q <= out_cnt_q;     // None, or one in one out
            endcase
        end
    end

    // ============================================================
    // Beat countdown
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n || ctrl.start) begin
            burst_active_q <= 1'b0;
            beats_left_q   <= '0;
        end else if (ar_fire) begin
            burst_active_q <= 1'b1;
            beats_left_q   <= CD_W'(`FETCH_BEATS - 1);
        end else if (last_fire) begin
            // Next burst follows directly when one more is open
            if (out_cnt_q > 1) begin
                beats_left_q <= CD_W'(`FETCH_BEATS - 1);
            end else begin
                burst_active_q <= 1'b0;
                beats_left_q   <= '0;
            end
        end else if (beat_fire && beats_left_q != 0) begin
            beats_left_q <= beats_left_q - 1'b1;
        end
    end

    // ============================================================
    // AR channel
    // ============================================================
    // Stable while pending: issued_q moves only on ar_fire
    assign burst_line = ctrl.base_addr + fetch_pkg::cmd_addr_t'(issued_q * `FETCH_BEATS);

    assign o_arvalid = ar_pending_q;
    assign o_arid    = id_q;
    assign o_araddr  = {`FETCH_PAGE_ID, 2'b00, burst_line, {`FETCH_BYTE_SHIFT{1'b0}}};
    assign o_arlen   = 8'(`FETCH_BEATS - 1);
    assign o_arsize  = 3'(`FETCH_BYTE_SHIFT);
    assign o_arburst = 2'b01;                   // INCR

    assign ctrl.no_outstanding = (out_cnt_q == 0);

    a_out_limit: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        out_cnt_q <= `FETCH_MAX_OUT);

    a_ar_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr) && $stable(o_arid));

endmodule : burst_tracker

// ==== logic/fetch_fsm.sv ====
/*
  Fetch sequencing. A fetch starts only on a rising i_fetch_en seen in IDLE;
  a level held high after done is ignored. o_fetch_done is one cycle wide,
  the cycle after DONE. Address and target are held for the whole fetch.
*/
`timescale 1ns/100ps

module fetch_fsm (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_fetch_en,
    input  fetch_pkg::cmd_addr_t i_fetch_addr,
    input  fetch_pkg::target_e   i_fetch_target,
    output logic                 o_fetch_done,
    fetch_ctrl_if.fsm            ctrl
);

    fetch_pkg::fetch_state_e state_q, state_d;
    logic                    fetch_en_q;     // Previous sample of i_fetch_en
    logic                    done_q;
    fetch_pkg::cmd_addr_t    base_addr_q;
    fetch_pkg::target_e      target_q;

    // ============================================================
    // Command capture
    // ============================================================
    assign ctrl.start = (state_q == fetch_pkg::IDLE) && i_fetch_en && !fetch_en_q;

    always_ff @(posedge i_clk) begin
        if (ctrl.start) begin
            base_addr_q <= i_fetch_addr;
            target_q    <= i_fetch_target;
        end
    end

    // ============================================================
    // State machine
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q    <= fetch_pkg::IDLE;
            fetch_en_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            state_q    <= state_d;
            fetch_en_q <= i_fetch_en;
            done_q     <= (state_q == fetch_pkg::DONE);  // Pulse after DONE
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::IDLE:   if (ctrl.start) state_d = fetch_pkg::INIT;
            fetch_pkg::INIT:   state_d = fetch_pkg::ACTIVE;  // First AR already raised
            fetch_pkg::ACTIVE: begin
                // Lines can finish before the last rlast count settles
                if (ctrl.lines_done) begin
                    state_d = ctrl.no_outstanding ? fetch_pkg::DONE : fetch_pkg::DRAIN;
                end
            end
            fetch_pkg::DRAIN:  if (ctrl.no_outstanding) state_d = fetch_pkg::DONE;
            fetch_pkg::DONE:   state_d = fetch_pkg::IDLE;
            default:           state_d = fetch_pkg::IDLE;
        endcase
    end

    assign ctrl.issue_en  = (state_q == fetch_pkg::INIT) || (state_q == fetch_pkg::ACTIVE);
    assign ctrl.rd_en     = (state_q == fetch_pkg::ACTIVE) || (state_q == fetch_pkg::DRAIN);
    assign ctrl.base_addr = base_addr_q;
    assign ctrl.target    = target_q;
    assign o_fetch_done   = done_q;

    // New command only once the last fetch has no burst open
    a_start_idle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        ctrl.start |-> ctrl.no_outstanding);

endmodule : fetch_fsm

// ==== logic/fetch_ctrl_if.sv ====
/*
  Control and status between the FSM, the burst tracker and the line writer.
  start is a single-cycle pulse; counters in tracker and writer clear on it.
*/
`timescale 1ns/100ps

interface fetch_ctrl_if;

    logic                 start;           // Command accepted
    logic                 issue_en;        // AR issue allowed (INIT, ACTIVE)
    logic                 rd_en;           // rready (ACTIVE, DRAIN)
    fetch_pkg::cmd_addr_t base_addr;       // Registered command address
    fetch_pkg::target_e   target;          // Registered command target
    logic                 no_outstanding;  // Every issued burst returned
    logic                 lines_done;      // All 528 beats accepted

    modport fsm (
        output start, issue_en, rd_en, base_addr, target,
        input  no_outstanding, lines_done
    );

    modport tracker (
        input  start, issue_en, rd_en, base_addr,
        output no_outstanding
    );

    modport writer (
        input  start, rd_en, target,
        output lines_done
    );

endinterface : fetch_ctrl_if

// ==== logic/fetch_pkg.sv ====
/*
  Types shared by the fetcher blocks.
  All widths follow fetch_defines.svh.
*/
`include "fetch_defines.svh"

package fetch_pkg;

    // Fetch sequencing
    typedef enum logic [2:0] {
        IDLE   = 3'd0,   // Wait for rising fetch enable
        INIT   = 3'd1,   // First AR raised here
        ACTIVE = 3'd2,   // Issue and receive
        DRAIN  = 3'd3,   // All lines in, bursts still open
        DONE   = 3'd4    // One cycle, then done pulse
    } fetch_state_e;

    // Line buffer side
    typedef enum logic {
        TARGET_LEFT  = 1'b0,
        TARGET_RIGHT = 1'b1
    } target_e;

    typedef logic [`FETCH_DATA_W-1:0]      line_t;
    typedef logic [`FETCH_AXI_ADDR_W-1:0]  axi_addr_t;
    typedef logic [`FETCH_CMD_ADDR_W-1:0]  cmd_addr_t;
    typedef logic [`FETCH_LINE_ADDR_W-1:0] line_addr_t;
    typedef logic [7:0]                    axi_id_t;

endpackage : fetch_pkg

// ==== include/fetch_defines.svh ====
/*
  Burst fetcher constants: one fetch is 33 bursts of 16 beats, 528 lines.
  Beats are 256 bits, so byte addresses carry a fixed shift of 5.
  The page ID and ID base are fixed for the memory path in use.
*/
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// ============================================================
// Widths
// ============================================================
`define FETCH_DATA_W       256     // One line, one beat
`define FETCH_AXI_ADDR_W   42      // AXI byte address
`define FETCH_CMD_ADDR_W   26      // Line address from the command
`define FETCH_LINE_ADDR_W  11      // Line buffer, 0..527

// ============================================================
// Burst geometry and flow control
// ============================================================
`define FETCH_BEATS        16      // Beats per burst
`define FETCH_BURSTS       33      // Bursts per fetch
`define FETCH_LINES        528     // Beats x bursts
`define FETCH_MAX_OUT      6       // Outstanding burst limit
`define FETCH_PREDICT      3       // Issue next AR this many beats early
`define FETCH_BYTE_SHIFT   5       // 32 bytes per beat
`define FETCH_PAGE_ID      9'd2    // Top bits of araddr
`define FETCH_ID_BASE      8'hFE   // First arid of a fetch

`endif
